// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;
    typedef logic [1:0]  wb_sel_t;

    // RV32I major opcodes
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    localparam alu_op_t ALU_SLT    = 3'd5;
    localparam alu_op_t ALU_PASS_B = 3'd6;

    // Operand source at decode
    localparam fwd_sel_t FWD_RF  = 2'd0;
    localparam fwd_sel_t FWD_EX  = 2'd1;
    localparam fwd_sel_t FWD_MEM = 2'd2;

    localparam wb_sel_t WB_ALU  = 2'd0;
    localparam wb_sel_t WB_MEM  = 2'd1;
    localparam wb_sel_t WB_LINK = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                clk,
    input  wire                i_reset,
    input  wire                i_freeze,
    input  wire                i_stall,
    input  wire                i_redirect,
    input  wire rv_pkg::word_t i_target,
    input  wire rv_pkg::word_t i_instr,
    output rv_pkg::word_t      o_pc,
    output rv_pkg::word_t      o_id_pc,
    output rv_pkg::word_t      o_id_instr,
    output logic               o_id_valid
);
    import rv_pkg::*;

    word_t pc_next;

    assign pc_next = o_pc + 32'd4;

    // Redirect beats stall for the PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc       <= RESET_PC;
            o_id_valid <= 1'b0;
        end else if (!i_freeze) begin
            if (i_redirect) begin
                o_pc       <= i_target;
                o_id_valid <= 1'b0;
            end else if (!i_stall) begin
                o_pc       <= pc_next;
                o_id_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze && !i_stall) begin
            o_id_pc    <= o_pc;
            o_id_instr <= i_instr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  wire                   clk,
    input  wire                   i_reset,
    input  wire                   i_freeze,
    input  wire                   i_stall,
    input  wire                   i_flush,
    input  wire rv_pkg::word_t    i_pc,
    input  wire rv_pkg::word_t    i_instr,
    input  wire                   i_valid,
    input  wire rv_pkg::word_t    i_rs1_data,
    input  wire rv_pkg::word_t    i_rs2_data,
    input  wire rv_pkg::fwd_sel_t i_fwd1,
    input  wire rv_pkg::fwd_sel_t i_fwd2,
    input  wire rv_pkg::word_t    i_ex_value,
    input  wire rv_pkg::word_t    i_mem_value,
    output rv_pkg::reg_addr_t     o_rs1,
    output rv_pkg::reg_addr_t     o_rs2,
    output logic                  o_ex_valid,
    output rv_pkg::word_t         o_ex_pc,
    output rv_pkg::word_t         o_ex_a,
    output rv_pkg::word_t         o_ex_b,
    output rv_pkg::word_t         o_ex_imm,
    output rv_pkg::alu_op_t       o_ex_alu_op,
    output rv_pkg::opcode_t       o_ex_opcode,
    output rv_pkg::reg_addr_t     o_ex_rd,
    output rv_pkg::reg_addr_t     o_ex_rs2,
    output rv_pkg::wb_sel_t       o_ex_wb_sel
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    word_t      imm;
    alu_op_t    alu_op;
    wb_sel_t    wb_sel;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       writes_rd;

    function automatic word_t pick(input fwd_sel_t sel, input word_t rf_value,
                                   input word_t ex_value, input word_t mem_value);
        case (sel)
            FWD_EX:  return ex_value;
            FWD_MEM: return mem_value;
            default: return rf_value;
        endcase
    endfunction

    assign opcode    = i_instr[6:0];
    assign funct3    = i_instr[14:12];
    assign uses_rs1  = (opcode != OP_LUI) && (opcode != OP_JAL);
    assign uses_rs2  = (opcode == OP_REG) || (opcode == OP_STORE) || (opcode == OP_BRANCH);
    assign writes_rd = (opcode != OP_STORE) && (opcode != OP_BRANCH);

    // Unused sources read as x0 so they never match a hazard
    assign o_rs1 = (i_valid && uses_rs1) ? i_instr[19:15] : '0;
    assign o_rs2 = (i_valid && uses_rs2) ? i_instr[24:20] : '0;
    assign rd    = writes_rd ? i_instr[11:7] : '0;

    always_comb begin
        imm    = {{20{i_instr[31]}}, i_instr[31:20]};
        alu_op = ALU_ADD;
        wb_sel = WB_ALU;
        case (opcode)
            OP_REG, OP_IMM: begin
                case (funct3)
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    3'b010:  alu_op = ALU_SLT;
                    default: alu_op = (opcode == OP_REG && i_instr[30]) ? ALU_SUB : ALU_ADD;
                endcase
            end
            OP_LUI: begin
                imm    = {i_instr[31:12], 12'b0};
                alu_op = ALU_PASS_B;
            end
            OP_LOAD: begin
                wb_sel = WB_MEM;
            end
            OP_STORE: begin
                imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            OP_BRANCH: begin
                imm    = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                          i_instr[30:25], i_instr[11:8], 1'b0};
                // BEQ tests a zero difference, BNE a nonzero XOR
                alu_op = funct3[0] ? ALU_XOR : ALU_SUB;
            end
            OP_JAL: begin
                imm    = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                          i_instr[20], i_instr[30:21], 1'b0};
                wb_sel = WB_LINK;
            end
            default: begin
                alu_op = ALU_ADD;
            end
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ex_valid <= 1'b0;
        end else if (!i_freeze) begin
            o_ex_valid <= i_valid && !i_stall && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_ex_pc     <= i_pc;
            o_ex_a      <= pick(i_fwd1, i_rs1_data, i_ex_value, i_mem_value);
            o_ex_b      <= pick(i_fwd2, i_rs2_data, i_ex_value, i_mem_value);
            o_ex_imm    <= imm;
            o_ex_alu_op <= alu_op;
            o_ex_opcode <= opcode;
            o_ex_rd     <= rd;
            o_ex_rs2    <= o_rs2;
            o_ex_wb_sel <= wb_sel;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                    clk,
    input  wire                    i_reset,
    input  wire                    i_we,
    input  wire rv_pkg::reg_addr_t i_waddr,
    input  wire rv_pkg::word_t     i_wdata,
    input  wire rv_pkg::reg_addr_t i_raddr1,
    input  wire rv_pkg::reg_addr_t i_raddr2,
    output rv_pkg::word_t          o_rdata1,
    output rv_pkg::word_t          o_rdata2
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // Writeback value bypasses straight to decode
    assign o_rdata1 = (i_raddr1 == '0) ? '0 :
                      (i_we && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 :
                      (i_we && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire rv_pkg::reg_addr_t i_id_rs1,
    input  wire rv_pkg::reg_addr_t i_id_rs2,
    input  wire                    i_ex_valid,
    input  wire rv_pkg::opcode_t   i_ex_opcode,
    input  wire rv_pkg::reg_addr_t i_ex_rd,
    input  wire                    i_mem_valid,
    input  wire rv_pkg::reg_addr_t i_mem_rd,
    input  wire                    i_mem_write,
    input  wire                    i_mem_req,
    input  wire                    i_acki_n,
    input  wire                    i_ackd_n,
    output rv_pkg::fwd_sel_t       o_fwd1,
    output rv_pkg::fwd_sel_t       o_fwd2,
    output logic                   o_stall,
    output logic                   o_freeze
);
    import rv_pkg::*;

    logic ex_writes;
    logic mem_writes;
    logic ex_load;

    // Youngest producer wins
    function automatic fwd_sel_t source(input reg_addr_t rs, input logic ex_w,
                                        input reg_addr_t ex_rd, input logic mem_w,
                                        input reg_addr_t mem_rd);
        if (ex_w && rs == ex_rd) begin
            return FWD_EX;
        end else if (mem_w && rs == mem_rd) begin
            return FWD_MEM;
        end
        return FWD_RF;
    endfunction

    assign ex_writes  = i_ex_valid && (i_ex_rd != '0);
    assign mem_writes = i_mem_valid && !i_mem_write && (i_mem_rd != '0);
    assign ex_load    = ex_writes && (i_ex_opcode == OP_LOAD);

    assign o_fwd1 = source(i_id_rs1, ex_writes, i_ex_rd, mem_writes, i_mem_rd);
    assign o_fwd2 = source(i_id_rs2, ex_writes, i_ex_rd, mem_writes, i_mem_rd);

    // Load data not ready until MEM
    assign o_stall  = ex_load && ((i_id_rs1 == i_ex_rd) || (i_id_rs2 == i_ex_rd));
    assign o_freeze = i_acki_n || (i_mem_req && i_ackd_n);

endmodule

`default_nettype wire

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire                    clk,
    input  wire                    i_reset,
    input  wire                    i_freeze,
    input  wire                    i_valid,
    input  wire rv_pkg::word_t     i_pc,
    input  wire rv_pkg::word_t     i_a,
    input  wire rv_pkg::word_t     i_b,
    input  wire rv_pkg::word_t     i_imm,
    input  wire rv_pkg::alu_op_t   i_alu_op,
    input  wire rv_pkg::opcode_t   i_opcode,
    input  wire rv_pkg::reg_addr_t i_rd,
    input  wire rv_pkg::reg_addr_t i_rs2,
    input  wire rv_pkg::wb_sel_t   i_wb_sel,
    input  wire rv_pkg::word_t     i_wb_value,
    input  wire rv_pkg::reg_addr_t i_wb_rd,
    input  wire                    i_wb_we,
    output logic                   o_redirect,
    output rv_pkg::word_t          o_target,
    output rv_pkg::word_t          o_ex_value,
    output logic                   o_mem_valid,
    output rv_pkg::opcode_t        o_mem_opcode,
    output rv_pkg::reg_addr_t      o_mem_rd,
    output rv_pkg::word_t          o_mem_alu,
    output rv_pkg::word_t          o_mem_store,
    output rv_pkg::word_t          o_mem_link,
    output rv_pkg::wb_sel_t        o_mem_wb_sel
);
    import rv_pkg::*;

    word_t op_b;
    word_t alu;
    word_t link;
    word_t store_data;
    logic  taken;
    logic  wb_hit;

    assign op_b = (i_opcode == OP_REG || i_opcode == OP_BRANCH) ? i_b : i_imm;

    always_comb begin
        case (i_alu_op)
            ALU_SUB:    alu = i_a - op_b;
            ALU_AND:    alu = i_a & op_b;
            ALU_OR:     alu = i_a | op_b;
            ALU_XOR:    alu = i_a ^ op_b;
            ALU_SLT:    alu = {31'b0, $signed(i_a) < $signed(op_b)};
            ALU_PASS_B: alu = op_b;
            default:    alu = i_a + op_b;
        endcase
    end

    assign taken      = (i_alu_op == ALU_SUB) ? (alu == '0) : (alu != '0);
    assign o_redirect = i_valid && ((i_opcode == OP_JAL) || (i_opcode == OP_BRANCH && taken));
    assign o_target   = i_pc + i_imm;
    assign link       = i_pc + 32'd4;
    assign o_ex_value = (i_wb_sel == WB_LINK) ? link : alu;

    // Store data from WB unless a newer writer sits in MEM
    assign wb_hit     = i_wb_we && (i_rs2 != '0) && (i_wb_rd == i_rs2) &&
                        !(o_mem_valid && o_mem_rd == i_rs2);
    assign store_data = wb_hit ? i_wb_value : i_b;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_mem_valid <= 1'b0;
        end else if (!i_freeze) begin
            o_mem_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_mem_opcode <= i_opcode;
            o_mem_rd     <= i_rd;
            o_mem_alu    <= alu;
            o_mem_store  <= store_data;
            o_mem_link   <= link;
            o_mem_wb_sel <= i_wb_sel;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_wb_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_wb_unit (
    input  wire                    clk,
    input  wire                    i_reset,
    input  wire                    i_freeze,
    input  wire                    i_mem_valid,
    input  wire rv_pkg::opcode_t   i_mem_opcode,
    input  wire rv_pkg::reg_addr_t i_mem_rd,
    input  wire rv_pkg::word_t     i_mem_alu,
    input  wire rv_pkg::word_t     i_mem_store,
    input  wire rv_pkg::word_t     i_mem_link,
    input  wire rv_pkg::wb_sel_t   i_mem_wb_sel,
    input  wire rv_pkg::word_t     i_ddt_rd,
    output rv_pkg::word_t          o_dad,
    output rv_pkg::word_t          o_ddt_wr,
    output logic                   o_mreq,
    output logic                   o_write,
    output rv_pkg::word_t          o_mem_value,
    output logic                   o_wb_we,
    output rv_pkg::reg_addr_t      o_wb_rd,
    output rv_pkg::word_t          o_wb_value
);
    import rv_pkg::*;

    logic is_load;
    logic wb_valid_q;

    assign is_load  = i_mem_valid && (i_mem_opcode == OP_LOAD);
    assign o_write  = i_mem_valid && (i_mem_opcode == OP_STORE);
    assign o_mreq   = is_load || o_write;
    assign o_dad    = i_mem_alu;
    assign o_ddt_wr = i_mem_store;

    always_comb begin
        case (i_mem_wb_sel)
            WB_MEM:  o_mem_value = i_ddt_rd;
            WB_LINK: o_mem_value = i_mem_link;
            default: o_mem_value = i_mem_alu;
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wb_valid_q <= 1'b0;
        end else if (!i_freeze) begin
            wb_valid_q <= i_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_freeze) begin
            o_wb_rd    <= i_mem_rd;
            o_wb_value <= o_mem_value;
        end
    end

    // No register write while the pipe is frozen
    assign o_wb_we = wb_valid_q && !i_freeze;

endmodule

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                clk,
    input  wire                i_reset,

    // Instruction memory
    output rv_pkg::word_t      o_iad,
    input  wire rv_pkg::word_t i_idt,
    input  wire                i_acki_n,

    // Data memory
    output rv_pkg::word_t      o_dad,
    output rv_pkg::word_t      o_ddt_wr,
    input  wire rv_pkg::word_t i_ddt_rd,
    output logic               o_mreq,
    output logic               o_write,
    input  wire                i_ackd_n
);
    import rv_pkg::*;

    // IF/ID
    word_t     id_pc, id_instr;
    logic      id_valid;
    reg_addr_t id_rs1, id_rs2;
    word_t     rs1_data, rs2_data;

    // ID/EX
    logic      ex_valid;
    word_t     ex_pc, ex_a, ex_b, ex_imm, ex_value;
    alu_op_t   ex_alu_op;
    opcode_t   ex_opcode;
    reg_addr_t ex_rd, ex_rs2;
    wb_sel_t   ex_wb_sel;

    // EX/MEM
    logic      mem_valid;
    opcode_t   mem_opcode;
    reg_addr_t mem_rd;
    word_t     mem_alu, mem_store, mem_link, mem_value;
    wb_sel_t   mem_wb_sel;

    // MEM/WB
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_value;

    // Pipeline control
    fwd_sel_t  fwd1, fwd2;
    logic      stall;
    logic      freeze;
    logic      redirect;
    word_t     target;

    fetch_unit #(.RESET_PC(RESET_PC)) fetch_unit_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_freeze(freeze),
        .i_stall(stall),
        .i_redirect(redirect),
        .i_target(target),
        .i_instr(i_idt),
        .o_pc(o_iad),
        .o_id_pc(id_pc),
        .o_id_instr(id_instr),
        .o_id_valid(id_valid)
    );

    decode_unit decode_unit_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_freeze(freeze),
        .i_stall(stall),
        .i_flush(redirect),
        .i_pc(id_pc),
        .i_instr(id_instr),
        .i_valid(id_valid),
        .i_rs1_data(rs1_data),
        .i_rs2_data(rs2_data),
        .i_fwd1(fwd1),
        .i_fwd2(fwd2),
        .i_ex_value(ex_value),
        .i_mem_value(mem_value),
        .o_rs1(id_rs1),
        .o_rs2(id_rs2),
        .o_ex_valid(ex_valid),
        .o_ex_pc(ex_pc),
        .o_ex_a(ex_a),
        .o_ex_b(ex_b),
        .o_ex_imm(ex_imm),
        .o_ex_alu_op(ex_alu_op),
        .o_ex_opcode(ex_opcode),
        .o_ex_rd(ex_rd),
        .o_ex_rs2(ex_rs2),
        .o_ex_wb_sel(ex_wb_sel)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_we(wb_we),
        .i_waddr(wb_rd),
        .i_wdata(wb_value),
        .i_raddr1(id_rs1),
        .i_raddr2(id_rs2),
        .o_rdata1(rs1_data),
        .o_rdata2(rs2_data)
    );

    hazard_unit hazard_unit_inst (
        .i_id_rs1(id_rs1),
        .i_id_rs2(id_rs2),
        .i_ex_valid(ex_valid),
        .i_ex_opcode(ex_opcode),
        .i_ex_rd(ex_rd),
        .i_mem_valid(mem_valid),
        .i_mem_rd(mem_rd),
        .i_mem_write(o_write),
        .i_mem_req(o_mreq),
        .i_acki_n(i_acki_n),
        .i_ackd_n(i_ackd_n),
        .o_fwd1(fwd1),
        .o_fwd2(fwd2),
        .o_stall(stall),
        .o_freeze(freeze)
    );

    execute_unit execute_unit_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_freeze(freeze),
        .i_valid(ex_valid),
        .i_pc(ex_pc),
        .i_a(ex_a),
        .i_b(ex_b),
        .i_imm(ex_imm),
        .i_alu_op(ex_alu_op),
        .i_opcode(ex_opcode),
        .i_rd(ex_rd),
        .i_rs2(ex_rs2),
        .i_wb_sel(ex_wb_sel),
        .i_wb_value(wb_value),
        .i_wb_rd(wb_rd),
        .i_wb_we(wb_we),
        .o_redirect(redirect),
        .o_target(target),
        .o_ex_value(ex_value),
        .o_mem_valid(mem_valid),
        .o_mem_opcode(mem_opcode),
        .o_mem_rd(mem_rd),
        .o_mem_alu(mem_alu),
        .o_mem_store(mem_store),
        .o_mem_link(mem_link),
        .o_mem_wb_sel(mem_wb_sel)
    );

    mem_wb_unit mem_wb_unit_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_freeze(freeze),
        .i_mem_valid(mem_valid),
        .i_mem_opcode(mem_opcode),
        .i_mem_rd(mem_rd),
        .i_mem_alu(mem_alu),
        .i_mem_store(mem_store),
        .i_mem_link(mem_link),
        .i_mem_wb_sel(mem_wb_sel),
        .i_ddt_rd(i_ddt_rd),
        .o_dad(o_dad),
        .o_ddt_wr(o_ddt_wr),
        .o_mreq(o_mreq),
        .o_write(o_write),
        .o_mem_value(mem_value),
        .o_wb_we(wb_we),
        .o_wb_rd(wb_rd),
        .o_wb_value(wb_value)
    );

endmodule

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam logic [31:0] RESET_PC  = 32'h0000_0000;
    localparam int          MEM_WORDS = 64;
    localparam int          TIMEOUT   = 5000;
    localparam int          SEED      = 36503;
    // Word offsets of the sections in the stim file
    localparam int          DATA_BASE = 'h08;
    localparam int          CODE_BASE = 'h10;
    localparam int          EXP_BASE  = 'h60;

    logic        clk;
    logic        i_reset;
    logic [31:0] o_iad;
    logic [31:0] i_idt;
    logic        i_acki_n;
    logic [31:0] o_dad;
    logic [31:0] o_ddt_wr;
    logic [31:0] i_ddt_rd;
    logic        o_mreq;
    logic        o_write;
    logic        i_ackd_n;

    logic [31:0] stim [0:127];
    logic [31:0] imem [0:MEM_WORDS-1];
    logic [31:0] dmem [0:MEM_WORDS-1];

    int n_code;
    int n_data;
    int n_stores;
    int pct_i;
    int pct_d;
    int store_idx;
    int run_test;
    int total_errors;
    int passed;
    int test_errors [1:5];

    rv_core_top #(.RESET_PC(RESET_PC)) dut_i (
        .clk(clk),
        .i_reset(i_reset),
        .o_iad(o_iad),
        .i_idt(i_idt),
        .i_acki_n(i_acki_n),
        .o_dad(o_dad),
        .o_ddt_wr(o_ddt_wr),
        .i_ddt_rd(i_ddt_rd),
        .o_mreq(o_mreq),
        .o_write(o_write),
        .i_ackd_n(i_ackd_n)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = (addr - RESET_PC) >> 2;
        if (offset < MEM_WORDS) begin
            return imem[offset[5:0]];
        end
        return 32'h0000_0013;
    endfunction

    // Test owning the store at idx, or the wait-state run
    function automatic int group_of(input int idx);
        int last;
        if (run_test != 0) begin
            return run_test;
        end
        last = (idx < n_stores) ? idx : n_stores - 1;
        return int'(stim[EXP_BASE + 3 * last]);
    endfunction

    task automatic note_error(input int id);
        test_errors[id] = test_errors[id] + 1;
        total_errors = total_errors + 1;
    endtask

    task automatic load_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            // Filler is addi x0, x0, index
            imem[i] = {i[11:0], 20'h00013};
            dmem[i] = 32'hda7a_0000 | i;
        end
        for (int i = 0; i < n_code; i++) begin
            imem[i] = stim[CODE_BASE + i];
        end
        for (int i = 0; i < n_data; i++) begin
            dmem[i] = stim[DATA_BASE + i];
        end
    endtask

    task automatic drive_memories();
        logic fetch_wait;
        logic data_wait;
        fetch_wait = int'($urandom % 100) < pct_i;
        // Data side only acks together with the fetch side
        data_wait = fetch_wait || (int'($urandom % 100) < pct_d);
        i_acki_n = fetch_wait;
        i_ackd_n = data_wait;
        i_idt    = fetch_word(o_iad);
        i_ddt_rd = dmem[o_dad[7:2]];
    endtask

    task automatic check_store();
        int          id;
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        id = group_of(store_idx);
        if (store_idx >= n_stores) begin
            $display("Unexpected extra store at %0t ns to address %h", $time, o_dad);
            note_error(id);
        end else begin
            exp_addr = stim[EXP_BASE + 3 * store_idx + 1];
            exp_data = stim[EXP_BASE + 3 * store_idx + 2];
            if (o_dad !== exp_addr) begin
                $display("error at %0t ns: o_dad = %h, expected %h", $time, o_dad, exp_addr);
                note_error(id);
            end
            if (o_ddt_wr !== exp_data) begin
                $display("error at %0t ns: o_ddt_wr = %h, expected %h",
                         $time, o_ddt_wr, exp_data);
                note_error(id);
            end
        end
        dmem[o_dad[7:2]] = o_ddt_wr;
        store_idx = store_idx + 1;
    endtask

    task automatic start_program(input int rate_i, input int rate_d);
        @(posedge clk);
        #1;
        i_reset   = 1'b1;
        pct_i     = rate_i;
        pct_d     = rate_d;
        store_idx = 0;
        load_memories();
        repeat (8) @(posedge clk);
        #1;
        i_reset = 1'b0;
    endtask

    task automatic wait_for_stores();
        int cycles;
        cycles = 0;
        while (store_idx < n_stores && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (store_idx < n_stores) begin
            $display("Timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, store_idx, n_stores);
            note_error(group_of(store_idx));
        end
        // Idle loop keeps running, so a late or repeated store shows up here
        repeat (40) @(posedge clk);
    endtask

    task automatic report_test(input int id, input string name);
        if (test_errors[id] == 0) begin
            passed = passed + 1;
            $display("Test %0d %s: passed", id, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", id, name, test_errors[id]);
        end
    endtask

    // Drive memory responses just after the rising edge
    always @(posedge clk) begin
        #1;
        drive_memories();
    end

    // A store completes at the next edge when acked
    always @(negedge clk) begin
        if (!i_reset && o_mreq && o_write && !i_ackd_n) begin
            check_store();
        end
    end

    initial begin
        i_reset      = 1'b1;
        i_idt        = '0;
        i_acki_n     = 1'b1;
        i_ddt_rd     = '0;
        i_ackd_n     = 1'b1;
        pct_i        = 0;
        pct_d        = 0;
        store_idx    = 0;
        run_test     = 0;
        total_errors = 0;
        passed       = 0;
        for (int i = 1; i <= 5; i++) begin
            test_errors[i] = 0;
        end
        void'($urandom(SEED));
        $readmemh("tests/core_stim.txt", stim);
        n_code   = int'(stim[0]);
        n_data   = int'(stim[1]);
        n_stores = int'(stim[2]);

        start_program(0, 0);
        #1;
        if (o_mreq !== 1'b0) begin
            $display("error at %0t ns: o_mreq = %b, expected 0", $time, o_mreq);
            note_error(1);
        end
        if (o_write !== 1'b0) begin
            $display("error at %0t ns: o_write = %b, expected 0", $time, o_write);
            note_error(1);
        end
        if (o_iad !== RESET_PC) begin
            $display("error at %0t ns: o_iad = %h, expected %h", $time, o_iad, RESET_PC);
            note_error(1);
        end
        report_test(1, "reset state");

        wait_for_stores();
        report_test(2, "ALU and LUI results");
        report_test(3, "load-use");
        report_test(4, "branches and JAL");

        run_test = 5;
        start_program(int'(stim[3]), int'(stim[4]));
        wait_for_stores();
        report_test(5, "random wait states");

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 passed, 5 - passed, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/core_stim.txt ====
// @00 header: code words, data words, stores, fetch wait %, data wait % (all hex)
// @08 data words, @10 program words, @60 stores as: test, address, data
@00
00000023 00000002 0000000A 00000019 0000001E
@08
00001000 CAFEF00D
@10
// ALU and LUI chain, then stores of each result
123450B7 67808113 FFB00193 40310233 002242B3 0051A333 004363B3 0F017413
003104B3 04402023 04502223 04602423 04702623 04802823 04902A23
// Load-use into ADD, and load straight into store
00002503 003505B3 04B02C23 00402603 04C02E23
// Branches and JAL with stores in each shadow
00700693 00368663 06D02023 00369663 06102223 06202223 00D68663 06102223
06202223 00D69463 00C0076F 06102223 06202223 06E02423 0000006F
@60
00000002 00000040 1234567D
00000002 00000044 00000005
00000002 00000048 00000001
00000002 0000004C 1234567D
00000002 00000050 00000070
00000002 00000054 12345673
00000003 00000058 00000FFB
00000003 0000005C CAFEF00D
00000004 00000060 00000007
00000004 00000068 0000007C

// ==== vlog.f ====
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/execute_unit.sv
hdl/mem_wb_unit.sv
hdl/rv_core_top.sv
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core \
    -f vlog.f -o tb_rv_core
./obj_dir/tb_rv_core | tee sim.log
if grep -q "^Done: no errors$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
